// ==== Makefile ====
# Verilator build and run for the quad BRAM job controller

VERILATOR ?= verilator
TOP       ?= tb_quad_bram_ctrl
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(wildcard src/*.sv) $(wildcard tb/*.sv) $(wildcard include/*.svh)
BINARY  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BINARY)
	./$(BINARY) | tee $(LOG)
	@grep -qx "TEST PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== compile.f ====
+incdir+include
src/geom_pkg.sv
src/ctrl_pkg.sv
src/delay_line.sv
src/pfb_reader.sv
src/pix_seq_reader.sv
src/job_ctrl.sv
src/quad_bram_ctrl.sv
tb/tb_quad_bram_ctrl.sv

// ==== include/accel_defs.svh ====
`ifndef ACCEL_DEFS_SVH
`define ACCEL_DEFS_SVH

// Words per BRAM
`define BRAM_DEPTH 1024

// Engine and compute element counts
`define NUM_AWE 2
`define NUM_CE_PER_AWE 4

// Sequence reads per output step
`define SEQ_STEP_CYCLES 5

// Sequence BRAM read latency in cycles
`define SEQ_RD_LATENCY 3

// Length of the job accept strobe
`define ACCEPT_STRETCH 5

// Input rows primed before execution starts
`define PRIME_ROWS 4

`endif

// ==== src/ctrl_pkg.sv ====
`default_nettype none

package ctrl_pkg;

    // One-hot controller states
    typedef enum logic [5:0] {
        ST_IDLE      = 6'b000001,
        ST_PRIME     = 6'b000010,
        ST_WAIT_LOAD = 6'b000100,
        ST_ACTIVE    = 6'b001000,
        ST_FINISH    = 6'b010000,
        ST_DONE      = 6'b100000
    } ctrl_state_t;

    // What the controller asks of a read side
    typedef enum logic [1:0] {
        MODE_OFF    = 2'd0,
        MODE_PRIME  = 2'd1,
        MODE_ACTIVE = 2'd2,
        MODE_FINISH = 2'd3
    } side_mode_t;

endpackage

`default_nettype wire

// ==== src/delay_line.sv ====
`timescale 1ns/1ps
`default_nettype none

module delay_line #(
    parameter int DEPTH = 3,
    parameter type T = logic
) (
    input  wire clk,
    input  wire rst,
    input  wire T din,
    output T    dout
);

    T stage [DEPTH];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                stage[i] <= '0;
            end
        end else begin
            stage[0] <= din;
            for (int i = 1; i < DEPTH; i++) begin
                stage[i] <= stage[i-1];
            end
        end
    end

    assign dout = stage[DEPTH-1];

endmodule

`default_nettype wire

// ==== src/geom_pkg.sv ====
`default_nettype none

`include "accel_defs.svh"

package geom_pkg;

    // Map coordinates span half a BRAM
    localparam int COORD_W = $clog2(`BRAM_DEPTH) - 1;

    typedef logic [COORD_W-1:0] coord_t;
    typedef logic [8:0] pfb_count_t;
    typedef logic [11:0] seq_addr_t;

    // Phase within one output step
    typedef logic [2:0] step_t;

    // One execute bit per compute element
    typedef logic [`NUM_AWE*`NUM_CE_PER_AWE-1:0] ce_vec_t;

endpackage

`default_nettype wire

// ==== src/job_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "accel_defs.svh"

module job_ctrl
    import ctrl_pkg::*;
(
    input  wire        clk,
    input  wire        rst,
    input  wire        job_start,
    output logic       job_accept,
    output logic       job_fetch_request,
    output logic       job_fetch_in_progress,
    input  wire        job_fetch_ack,
    input  wire        job_fetch_complete,
    output logic       job_complete,
    input  wire        job_complete_ack,
    input  wire        pfb_drained,
    input  wire        prime_done,
    input  wire        input_row_end,
    input  wire        row_step_done,
    input  wire        job_step_done,
    input  wire        ce_busy,
    output side_mode_t pfb_mode,
    output logic       fetch_done,
    output logic       seq_start,
    output logic       seq_run
);

    localparam int ACC_W = $clog2(`ACCEPT_STRETCH + 1);

    ctrl_state_t      state;
    ctrl_state_t      resume_state;
    logic [ACC_W-1:0] accept_cnt;

    assign job_accept = accept_cnt != '0;
    assign fetch_done = state == ST_WAIT_LOAD && job_fetch_complete && job_fetch_in_progress;
    assign seq_run    = state == ST_ACTIVE;

    // Waiting keeps the mode of the state it returns to
    always_comb begin
        case (state)
            ST_PRIME:     pfb_mode = MODE_PRIME;
            ST_WAIT_LOAD: pfb_mode = (resume_state == ST_PRIME) ? MODE_PRIME : MODE_FINISH;
            ST_ACTIVE:    pfb_mode = MODE_ACTIVE;
            ST_FINISH:    pfb_mode = MODE_FINISH;
            default:      pfb_mode = MODE_OFF;
        endcase
    end

    // Accept strobe stretched over a fixed count
    always_ff @(posedge clk) begin
        if (rst) begin
            accept_cnt <= '0;
        end else if (state == ST_IDLE && job_start) begin
            accept_cnt <= ACC_W'(`ACCEPT_STRETCH);
        end else if (accept_cnt != '0) begin
            accept_cnt <= accept_cnt - 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Controller FSM
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            state                 <= ST_IDLE;
            resume_state          <= ST_PRIME;
            job_fetch_request     <= 1'b0;
            job_fetch_in_progress <= 1'b0;
            job_complete          <= 1'b0;
            seq_start             <= 1'b0;
        end else begin
            seq_start <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (job_start) begin
                        state <= ST_PRIME;
                    end
                end
                ST_PRIME: begin
                    if (prime_done) begin
                        seq_start <= 1'b1;
                        state     <= ST_ACTIVE;
                    end else if (pfb_drained) begin
                        resume_state <= ST_PRIME;
                        state        <= ST_WAIT_LOAD;
                    end
                end
                ST_WAIT_LOAD: begin
                    // Request once per load and hold it until acked
                    if (job_fetch_ack) begin
                        job_fetch_request     <= 1'b0;
                        job_fetch_in_progress <= 1'b1;
                    end else if (!job_fetch_in_progress) begin
                        job_fetch_request <= 1'b1;
                    end
                    if (fetch_done) begin
                        job_fetch_in_progress <= 1'b0;
                        state                 <= resume_state;
                    end
                end
                ST_ACTIVE: begin
                    if (job_step_done) begin
                        state <= ST_DONE;
                    end else if (row_step_done) begin
                        state <= ST_FINISH;
                    end
                end
                ST_FINISH: begin
                    if (pfb_drained && !input_row_end) begin
                        resume_state <= ST_FINISH;
                        state        <= ST_WAIT_LOAD;
                    end else if (!ce_busy) begin
                        seq_start <= 1'b1;
                        state     <= ST_ACTIVE;
                    end
                end
                ST_DONE: begin
                    if (job_complete_ack) begin
                        job_complete <= 1'b0;
                        state        <= ST_IDLE;
                    end else begin
                        job_complete <= 1'b1;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== src/pfb_reader.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "accel_defs.svh"

module pfb_reader
    import geom_pkg::*, ctrl_pkg::*;
(
    input  wire          clk,
    input  wire          rst,
    input  wire coord_t  num_input_cols,
    input  wire coord_t  num_input_rows,
    input  wire pfb_count_t pfb_full_count,
    input  wire          fetch_done,
    input  wire side_mode_t pfb_mode,
    input  wire          row_matric,
    input  wire          last_kernel,
    output logic         pfb_rden,
    output coord_t       input_row,
    output coord_t       input_col,
    output coord_t       row_matric_wr_addr,
    output logic         pfb_drained,
    output logic         prime_done,
    output logic         input_row_end
);

    pfb_count_t pfb_count;
    logic       pfb_avail;
    logic       row_rd;
    logic       rd_issue;

    // Words left once the read in flight has landed
    assign pfb_avail     = pfb_count > pfb_count_t'(pfb_rden);
    assign pfb_drained   = pfb_count == '0;
    assign prime_done    = input_row == coord_t'(`PRIME_ROWS - 1) &&
                           pfb_count == pfb_full_count;
    assign input_row_end = input_row == num_input_rows + coord_t'(1);

    always_comb begin
        row_rd   = 1'b0;
        rd_issue = 1'b0;
        case (pfb_mode)
            MODE_PRIME: begin
                rd_issue = pfb_avail && !prime_done;
            end
            MODE_ACTIVE, MODE_FINISH: begin
                // One word per row matrix slot, overlapped with execution
                row_rd   = row_matric && last_kernel && pfb_avail;
                rd_issue = row_rd;
            end
            default: begin
                rd_issue = 1'b0;
            end
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Word count and read strobe
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            pfb_count <= '0;
            pfb_rden  <= 1'b0;
        end else begin
            pfb_rden <= rd_issue;
            if (fetch_done) begin
                pfb_count <= pfb_full_count;
            end else if (pfb_rden) begin
                pfb_count <= pfb_count - 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Input position and row matrix address
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst || pfb_mode == MODE_OFF) begin
            input_row          <= '0;
            input_col          <= '0;
            row_matric_wr_addr <= '0;
        end else begin
            if (pfb_rden) begin
                if (input_col == num_input_cols) begin
                    input_col <= '0;
                    input_row <= input_row + 1'b1;
                end else begin
                    input_col <= input_col + 1'b1;
                end
            end
            if (row_rd) begin
                if (row_matric_wr_addr == num_input_cols) begin
                    row_matric_wr_addr <= '0;
                end else begin
                    row_matric_wr_addr <= row_matric_wr_addr + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/pix_seq_reader.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "accel_defs.svh"

module pix_seq_reader
    import geom_pkg::*;
(
    input  wire         clk,
    input  wire         rst,
    input  wire coord_t num_input_cols,
    input  wire coord_t num_input_rows,
    input  wire         seq_start,
    input  wire         seq_run,
    input  wire         last_kernel,
    output logic        pix_seq_rden,
    output seq_addr_t   pix_seq_rd_addr,
    output ce_vec_t     ce_execute,
    output logic        row_step_done,
    output logic        job_step_done,
    output logic        ce_busy
);

    localparam int    CE_W      = $bits(ce_vec_t);
    localparam step_t LAST_STEP = step_t'(`SEQ_STEP_CYCLES - 1);

    seq_addr_t seq_full_count;
    seq_addr_t seq_count;
    step_t     step;
    step_t     step_d;
    coord_t    output_col;
    coord_t    output_row;
    coord_t    output_col_d;
    coord_t    output_row_d;
    logic      exec_start;
    logic      rden_lat;
    logic      row_end_d;

    // One output step per column, padding column included
    assign seq_full_count = seq_addr_t'(`SEQ_STEP_CYCLES) *
                            (seq_addr_t'(num_input_cols) + 12'd1);

    // Last execute is registered, so one stage less here
    delay_line #(.DEPTH(`SEQ_RD_LATENCY - 1), .T(logic)) u_exec_dly (
        .clk  (clk),
        .rst  (rst),
        .din  (pix_seq_rden),
        .dout (exec_start)
    );

    delay_line #(.DEPTH(`SEQ_RD_LATENCY), .T(logic)) u_rden_dly (
        .clk  (clk),
        .rst  (rst),
        .din  (pix_seq_rden),
        .dout (rden_lat)
    );

    delay_line #(.DEPTH(`SEQ_RD_LATENCY), .T(coord_t)) u_col_dly (
        .clk  (clk),
        .rst  (rst),
        .din  (output_col),
        .dout (output_col_d)
    );

    delay_line #(.DEPTH(`SEQ_RD_LATENCY), .T(coord_t)) u_row_dly (
        .clk  (clk),
        .rst  (rst),
        .din  (output_row),
        .dout (output_row_d)
    );

    delay_line #(.DEPTH(`SEQ_RD_LATENCY), .T(step_t)) u_step_dly (
        .clk  (clk),
        .rst  (rst),
        .din  (step),
        .dout (step_d)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Sequence BRAM reads
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            seq_count       <= '0;
            pix_seq_rden    <= 1'b0;
            pix_seq_rd_addr <= '0;
        end else begin
            pix_seq_rden <= seq_run && !seq_start &&
                            seq_count > seq_addr_t'(pix_seq_rden);
            if (seq_start) begin
                seq_count <= seq_full_count;
            end else if (pix_seq_rden) begin
                seq_count <= seq_count - 1'b1;
            end
            if (pix_seq_rden) begin
                if (pix_seq_rd_addr == seq_full_count - 12'd1) begin
                    pix_seq_rd_addr <= '0;
                end else begin
                    pix_seq_rd_addr <= pix_seq_rd_addr + 1'b1;
                end
            end
        end
    end

    // Step phase, then output column, then output row
    always_ff @(posedge clk) begin
        if (rst) begin
            step       <= '0;
            output_col <= '0;
            output_row <= '0;
        end else if (pix_seq_rden) begin
            if (step == LAST_STEP) begin
                step <= '0;
                if (output_col == num_input_cols) begin
                    output_col <= '0;
                    if (last_kernel) begin
                        output_row <= (output_row == num_input_rows) ? '0
                                                                     : output_row + 1'b1;
                    end
                end else begin
                    output_col <= output_col + 1'b1;
                end
            end else begin
                step <= step + 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Execute strobes and step completion
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            ce_execute <= '0;
        end else begin
            ce_execute <= {ce_execute[CE_W-2:0], exec_start};
        end
    end

    assign ce_busy       = |ce_execute;
    assign row_end_d     = rden_lat && step_d == LAST_STEP && output_col_d == num_input_cols;
    assign row_step_done = row_end_d && output_row_d != num_input_rows;
    assign job_step_done = row_end_d && output_row_d == num_input_rows;

endmodule

`default_nettype wire

// ==== src/quad_bram_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module quad_bram_ctrl
    import geom_pkg::*, ctrl_pkg::*;
(
    input  wire             clk,
    input  wire             rst,
    input  wire coord_t     num_input_cols,
    input  wire coord_t     num_input_rows,
    input  wire             job_start,
    input  wire             job_fetch_ack,
    input  wire             job_fetch_complete,
    input  wire             job_complete_ack,
    input  wire pfb_count_t pfb_full_count,
    input  wire             row_matric,
    input  wire             last_kernel,
    output logic            job_accept,
    output logic            job_fetch_request,
    output logic            job_fetch_in_progress,
    output logic            job_complete,
    output logic            pfb_rden,
    output coord_t          input_row,
    output coord_t          input_col,
    output coord_t          row_matric_wr_addr,
    output ce_vec_t         ce_execute,
    output logic            pix_seq_rden,
    output seq_addr_t       pix_seq_rd_addr
);

    side_mode_t pfb_mode;
    logic       fetch_done;
    logic       seq_start;
    logic       seq_run;
    logic       pfb_drained;
    logic       prime_done;
    logic       input_row_end;
    logic       row_step_done;
    logic       job_step_done;
    logic       ce_busy;

    // Input side
    pfb_reader u_pfb_reader (
        .clk                (clk),
        .rst                (rst),
        .num_input_cols     (num_input_cols),
        .num_input_rows     (num_input_rows),
        .pfb_full_count     (pfb_full_count),
        .fetch_done         (fetch_done),
        .pfb_mode           (pfb_mode),
        .row_matric         (row_matric),
        .last_kernel        (last_kernel),
        .pfb_rden           (pfb_rden),
        .input_row          (input_row),
        .input_col          (input_col),
        .row_matric_wr_addr (row_matric_wr_addr),
        .pfb_drained        (pfb_drained),
        .prime_done         (prime_done),
        .input_row_end      (input_row_end)
    );

    // Output side
    pix_seq_reader u_pix_seq_reader (
        .clk             (clk),
        .rst             (rst),
        .num_input_cols  (num_input_cols),
        .num_input_rows  (num_input_rows),
        .seq_start       (seq_start),
        .seq_run         (seq_run),
        .last_kernel     (last_kernel),
        .pix_seq_rden    (pix_seq_rden),
        .pix_seq_rd_addr (pix_seq_rd_addr),
        .ce_execute      (ce_execute),
        .row_step_done   (row_step_done),
        .job_step_done   (job_step_done),
        .ce_busy         (ce_busy)
    );

    job_ctrl u_job_ctrl (
        .clk                   (clk),
        .rst                   (rst),
        .job_start             (job_start),
        .job_accept            (job_accept),
        .job_fetch_request     (job_fetch_request),
        .job_fetch_in_progress (job_fetch_in_progress),
        .job_fetch_ack         (job_fetch_ack),
        .job_fetch_complete    (job_fetch_complete),
        .job_complete          (job_complete),
        .job_complete_ack      (job_complete_ack),
        .pfb_drained           (pfb_drained),
        .prime_done            (prime_done),
        .input_row_end         (input_row_end),
        .row_step_done         (row_step_done),
        .job_step_done         (job_step_done),
        .ce_busy               (ce_busy),
        .pfb_mode              (pfb_mode),
        .fetch_done            (fetch_done),
        .seq_start             (seq_start),
        .seq_run               (seq_run)
    );

endmodule

`default_nettype wire

// ==== tb/tb_quad_bram_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "accel_defs.svh"

module tb_quad_bram_ctrl
    import geom_pkg::*;
();

    localparam int RESET_CYCLES   = 10;
    localparam int MAP_COLS       = 3;
    localparam int MAP_ROWS       = 5;
    localparam int PFB_LOAD       = MAP_COLS + 1;
    localparam int SEQ_LEN        = `SEQ_STEP_CYCLES * (MAP_COLS + 1);
    localparam int CE_W           = $bits(ce_vec_t);
    localparam int ACK_DELAY      = 3;
    localparam int COMPLETE_DELAY = 4;
    localparam int DONE_ACK_DELAY = 2;
    localparam int NUM_JOBS       = 2;
    localparam int CYCLE_LIMIT    = NUM_JOBS * SEQ_LEN * (MAP_ROWS + 1) * 3 + 400;

    logic       clk = 1'b0;
    logic       rst;
    coord_t     num_input_cols;
    coord_t     num_input_rows;
    logic       job_start;
    logic       job_fetch_ack;
    logic       job_fetch_complete;
    logic       job_complete_ack;
    pfb_count_t pfb_full_count;
    logic       row_matric;
    logic       last_kernel;
    logic       job_accept;
    logic       job_fetch_request;
    logic       job_fetch_in_progress;
    logic       job_complete;
    logic       pfb_rden;
    coord_t     input_row;
    coord_t     input_col;
    coord_t     row_matric_wr_addr;
    ce_vec_t    ce_execute;
    logic       pix_seq_rden;
    seq_addr_t  pix_seq_rd_addr;

    int          checks = 0;
    int          errors = 0;
    int          jobs_done = 0;
    int          cycle_count = 0;
    int          fetch_phase;
    int          fetch_wait;
    int          ack_wait;
    logic [31:0] rng_state = 32'd79311;

    // Reference model state updated on the falling edge
    int          accept_left;
    int          words_left;
    int          exp_col;
    int          exp_row;
    int          exp_addr;
    int          exp_wr;
    bit          model_idle;
    bit          job_seen;
    bit          exp_inprog;
    bit          req_blocked;
    bit          prev_complete;
    bit          prev_done_ack;
    logic [15:0] rd_hist;

    quad_bram_ctrl uut (
        .clk                   (clk),
        .rst                   (rst),
        .num_input_cols        (num_input_cols),
        .num_input_rows        (num_input_rows),
        .job_start             (job_start),
        .job_fetch_ack         (job_fetch_ack),
        .job_fetch_complete    (job_fetch_complete),
        .job_complete_ack      (job_complete_ack),
        .pfb_full_count        (pfb_full_count),
        .row_matric            (row_matric),
        .last_kernel           (last_kernel),
        .job_accept            (job_accept),
        .job_fetch_request     (job_fetch_request),
        .job_fetch_in_progress (job_fetch_in_progress),
        .job_complete          (job_complete),
        .pfb_rden              (pfb_rden),
        .input_row             (input_row),
        .input_col             (input_col),
        .row_matric_wr_addr    (row_matric_wr_addr),
        .ce_execute            (ce_execute),
        .pix_seq_rden          (pix_seq_rden),
        .pix_seq_rd_addr       (pix_seq_rd_addr)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic int wrap_increment(input int value, input int last);
        return (value == last) ? 0 : value + 1;
    endfunction

    task automatic compare_value(input string name, input int expected, input int actual);
        checks++;
        assert (expected == actual) else begin
            errors++;
            $display("Fail %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    task automatic confirm(input bit cond, input string what);
        checks++;
        assert (cond) else begin
            errors++;
            $display("Error at cycle %0d: %s", cycle_count, what);
        end
    endtask

    task automatic start_job();
        @(posedge clk);
        job_start <= 1'b1;
        @(posedge clk);
        job_start <= 1'b0;
    endtask

    task automatic wait_for_jobs(input int count);
        while (jobs_done < count) begin
            @(posedge clk);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Fetch, complete and row matrix models
    ////////////////////////////////////////////////////////////////////////////
    always @(posedge clk) begin
        job_fetch_ack      <= 1'b0;
        job_fetch_complete <= 1'b0;
        if (rst) begin
            fetch_phase = 0;
            fetch_wait  = 0;
        end else begin
            case (fetch_phase)
                0: begin
                    if (job_fetch_request) begin
                        fetch_wait  = ACK_DELAY;
                        fetch_phase = 1;
                    end
                end
                1: begin
                    if (fetch_wait == 0) begin
                        job_fetch_ack <= 1'b1;
                        fetch_wait  = COMPLETE_DELAY;
                        fetch_phase = 2;
                    end else begin
                        fetch_wait = fetch_wait - 1;
                    end
                end
                2: begin
                    if (fetch_wait == 0) begin
                        job_fetch_complete <= 1'b1;
                        fetch_phase = 3;
                    end else begin
                        fetch_wait = fetch_wait - 1;
                    end
                end
                default: begin
                    fetch_phase = 0;
                end
            endcase
        end
    end

    always @(posedge clk) begin
        job_complete_ack <= 1'b0;
        if (rst) begin
            ack_wait = 0;
        end else if (job_complete && !job_complete_ack) begin
            if (ack_wait == DONE_ACK_DELAY) begin
                job_complete_ack <= 1'b1;
                ack_wait = 0;
            end else begin
                ack_wait = ack_wait + 1;
            end
        end
    end

    // Row matrix slots come about three times in four
    always @(posedge clk) begin
        rng_state = xorshift32(rng_state);
        row_matric <= (rng_state[1:0] != 2'b00);
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: jobs did not complete within %0d cycles", CYCLE_LIMIT);
            $display("Checks run: %0d, errors: %0d, jobs completed: %0d",
                     checks, errors, jobs_done);
            $display("TEST FAILED");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checks on the falling edge
    ////////////////////////////////////////////////////////////////////////////
    always @(negedge clk) begin
        if (rst) begin
            accept_left   = 0;
            words_left    = 0;
            exp_col       = 0;
            exp_row       = 0;
            exp_addr      = 0;
            exp_wr        = 0;
            model_idle    = 1'b1;
            job_seen      = 1'b0;
            exp_inprog    = 1'b0;
            req_blocked   = 1'b0;
            prev_complete = 1'b0;
            prev_done_ack = 1'b0;
            rd_hist       = '0;
        end else begin
            // Quiet until the first job
            if (!job_seen) begin
                compare_value("quiet job_accept", 0, int'(job_accept));
                compare_value("quiet job_fetch_request", 0, int'(job_fetch_request));
                compare_value("quiet job_fetch_in_progress", 0, int'(job_fetch_in_progress));
                compare_value("quiet job_complete", 0, int'(job_complete));
                compare_value("quiet pfb_rden", 0, int'(pfb_rden));
                compare_value("quiet pix_seq_rden", 0, int'(pix_seq_rden));
                compare_value("quiet ce_execute", 0, int'(ce_execute));
                if (job_start) begin
                    job_seen = 1'b1;
                end
            end

            compare_value("job_accept", int'(accept_left != 0), int'(job_accept));
            if (accept_left != 0) begin
                accept_left--;
            end
            if (job_start && model_idle) begin
                accept_left = `ACCEPT_STRETCH;
                model_idle  = 1'b0;
            end

            // Fetch handshake
            compare_value("job_fetch_in_progress", int'(exp_inprog),
                          int'(job_fetch_in_progress));
            if (req_blocked) begin
                compare_value("job_fetch_request after ack", 0, int'(job_fetch_request));
            end
            if (job_fetch_ack) begin
                exp_inprog  = 1'b1;
                req_blocked = 1'b1;
            end
            if (job_fetch_complete && exp_inprog) begin
                exp_inprog  = 1'b0;
                req_blocked = 1'b0;
                words_left  = PFB_LOAD;
            end

            // Input position is cleared while the job is done
            if (job_complete) begin
                exp_col = 0;
                exp_row = 0;
                exp_wr  = 0;
            end
            compare_value("input_col", exp_col, int'(input_col));
            compare_value("input_row", exp_row, int'(input_row));
            if (pfb_rden) begin
                confirm(words_left > 0, "pfb_rden raised with no loaded words left");
                if (words_left > 0) begin
                    words_left--;
                end
                // Reads past the primed rows fill the row matrix
                if (exp_row >= `PRIME_ROWS - 1) begin
                    exp_wr = wrap_increment(exp_wr, MAP_COLS);
                end
                if (exp_col == MAP_COLS) begin
                    exp_col = 0;
                    exp_row++;
                end else begin
                    exp_col++;
                end
            end
            compare_value("row_matric_wr_addr", exp_wr, int'(row_matric_wr_addr));

            // Execute bit k trails its read by the latency plus k
            rd_hist = {rd_hist[14:0], pix_seq_rden};
            compare_value("ce_execute", int'(rd_hist[`SEQ_RD_LATENCY +: CE_W]),
                          int'(ce_execute));
            compare_value("pix_seq_rd_addr", exp_addr, int'(pix_seq_rd_addr));
            if (pix_seq_rden) begin
                exp_addr = wrap_increment(exp_addr, SEQ_LEN - 1);
            end

            // Job complete handshake
            if (prev_complete && prev_done_ack) begin
                compare_value("job_complete after ack", 0, int'(job_complete));
            end else if (prev_complete) begin
                compare_value("job_complete hold", 1, int'(job_complete));
            end
            if (job_complete && job_complete_ack) begin
                jobs_done++;
                model_idle = 1'b1;
            end
            prev_complete = job_complete;
            prev_done_ack = job_complete_ack;
        end
    end

    initial begin
        rst                <= 1'b1;
        num_input_cols     <= coord_t'(MAP_COLS);
        num_input_rows     <= coord_t'(MAP_ROWS);
        pfb_full_count     <= pfb_count_t'(PFB_LOAD);
        job_start          <= 1'b0;
        job_fetch_ack      <= 1'b0;
        job_fetch_complete <= 1'b0;
        job_complete_ack   <= 1'b0;
        row_matric         <= 1'b0;
        last_kernel        <= 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        repeat (5) @(posedge clk);
        for (int j = 1; j <= NUM_JOBS; j++) begin
            start_job();
            wait_for_jobs(j);
            repeat (6) @(posedge clk);
        end
        $display("Checks run: %0d, errors: %0d, jobs completed: %0d",
                 checks, errors, jobs_done);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
